// ==== flist.f ====
+incdir+include
hdl/ramPkg.sv
hdl/wordLineDecode.sv
hdl/ramPartition.sv
hdl/readSelect.sv
hdl/partitionedRam.sv
test/tbPartitionedRam.sv

// ==== Bender.yml ====
package:
  name: partitioned_ram

sources:
  - files:
      - hdl/ramPkg.sv
      - hdl/wordLineDecode.sv
      - hdl/ramPartition.sv
      - hdl/readSelect.sv
      - hdl/partitionedRam.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tbPartitionedRam.sv

// ==== include/tbRamTasks.svh ====
`ifndef TB_RAM_TASKS_SVH
`define TB_RAM_TASKS_SVH

// vectors shaped like the DUT ports
typedef logic [numRdPorts-1:0][ramIndex-1:0] rdAddrs_t;
typedef logic [numWrPorts-1:0][ramIndex-1:0] wrAddrs_t;
typedef logic [numWrPorts-1:0][ramWidth-1:0] wrData_t;

// reference model, word contents plus partition gates
logic [ramWidth-1:0] model [ramDepth];
bit                  gateModel [numParts];
bit                  modelReady;

int checkCount = 0;
int errorCount = 0;

task automatic checkWord(input string name, input logic [ramWidth-1:0] got,
                         input logic [ramWidth-1:0] exp);
  checkCount++;
  if (got !== exp)
  begin
    errorCount++;
    $display("Error: %s got %h expected %h", name, got, exp);
  end
endtask

task automatic checkReady(input string name, input logic got, input logic exp);
  checkCount++;
  if (got !== exp)
  begin
    errorCount++;
    $display("Error: %s got %h expected %h", name, got, exp);
  end
endtask

// after a fill, word i holds seqStart + i and nothing is gated
task automatic resetModel();
  for (int i = 0; i < ramDepth; i++)
  begin
    model[i] = (ramResetMode == RESET_SEQ) ? ramWidth'(seqStart + i) : '0;
  end
  modelReady = 1'b0;
endtask

// top address bits name the partition, a gated one reads zero
function automatic logic [ramWidth-1:0] expectRead(input logic [ramIndex-1:0] a);
  if (gateModel[a[ramIndex-1 -: numPartsLog]])
  begin
    return '0;
  end
  return model[a];
endfunction

function automatic rdAddrs_t readAddrs(input logic [ramIndex-1:0] a0, a1, a2, a3);
  rdAddrs_t ra;
  ra[0] = a0;
  ra[1] = a1;
  ra[2] = a2;
  ra[3] = a3;
  return ra;
endfunction

// one cycle of stimulus
// reads are checked at the falling edge, before the write lands
task automatic driveCycle(input logic [numWrPorts-1:0] en, input wrAddrs_t wa,
                          input wrData_t wd, input rdAddrs_t ra);
  logic [numPartsLog-1:0] part;
  @(posedge clk);
  wrEn   <= en;
  addrWr <= wa;
  dataWr <= wd;
  addr   <= ra;
  @(negedge clk);
  if (modelReady)
  begin
    for (int r = 0; r < numRdPorts; r++)
    begin
      checkWord($sformatf("data_o[%0d] at %h", r, ra[r]), dataRd[r], expectRead(ra[r]));
    end
    // port order gives the higher port the last word
    for (int w = 0; w < numWrPorts; w++)
    begin
      part = wa[w][ramIndex-1 -: numPartsLog];
      if (en[w] && !gateModel[part])
      begin
        model[wa[w]] = wd[w];
      end
    end
  end
endtask

task automatic setGate(input int part, input bit value);
  @(posedge clk);
  wrEn        <= '0;
  gated[part] <= value;
  gateModel[part] = value;
endtask

// reset held over two rising edges, ready checked low meanwhile
task automatic applyReset();
  @(posedge clk);
  rst  <= 1'b1;
  wrEn <= '0;
  @(posedge clk);
  @(negedge clk);
  checkReady("ramReady_o in reset", ramReady, 1'b0);
  @(posedge clk);
  rst <= 1'b0;
  @(negedge clk);
  checkReady("ramReady_o in reset", ramReady, 1'b0);
  resetModel();
endtask

task automatic waitReady();
  int cnt;
  cnt = 0;
  do
  begin
    @(posedge clk);
    wrEn <= '0;
    @(negedge clk);
    cnt++;
  end
  while (ramReady !== 1'b1 && cnt < 4 * partDepth);
  if (ramReady !== 1'b1)
  begin
    errorCount++;
    $display("ready flag did not rise within %0d cycles of the fill", cnt);
  end
  modelReady = 1'b1;
endtask

task automatic reportTest(input string name, input int errorsBefore);
  if (errorCount == errorsBefore)
  begin
    $display("%s: passed", name);
  end
  else
  begin
    $display("%s: failed with %0d errors", name, errorCount - errorsBefore);
  end
endtask

`endif

// ==== test/tbPartitionedRam.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbPartitionedRam;

  import ramPkg::*;

  // random phase dominates, the whole run is about a quarter of the limit
  localparam int numRandom  = 400;
  localparam int cycleLimit = 2000;

  logic                                 clk;
  logic                                 rst;
  logic [numParts-1:0]                  gated;
  logic [numRdPorts-1:0][ramIndex-1:0]  addr;
  logic [numWrPorts-1:0][ramIndex-1:0]  addrWr;
  logic [numWrPorts-1:0][ramWidth-1:0]  dataWr;
  logic [numWrPorts-1:0]                wrEn;
  logic [numRdPorts-1:0][ramWidth-1:0]  dataRd;
  logic                                 ramReady;
  int                                   cycleCount = 0;

  `include "tbRamTasks.svh"

  partitionedRam dut_i
  (
    .clk              (clk),
    .rst_i            (rst),
    .partitionGated_i (gated),
    .addr_i           (addr),
    .addrWr_i         (addrWr),
    .dataWr_i         (dataWr),
    .wrEn_i           (wrEn),
    .data_o           (dataRd),
    .ramReady_o       (ramReady)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // hard stop in case a wait never ends
  always @(posedge clk)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit)
    begin
      $display("run stopped after %0d cycles without finishing", cycleCount);
      $display("Simulation FAILED");
      $finish;
    end
  end

  // ready exactly partDepth edges after release, then every word
  task automatic fillAfterReset();
    int errs;
    errs = errorCount;
    applyReset();
    for (int i = 1; i <= partDepth; i++)
    begin
      @(posedge clk);
      @(negedge clk);
      checkReady($sformatf("ramReady_o edge %0d", i), ramReady, i == partDepth);
    end
    modelReady = 1'b1;
    // four words per cycle, one on each read port
    for (int b = 0; b < ramDepth; b += numRdPorts)
    begin
      driveCycle('0, '0, '0, readAddrs(b, b + 1, b + 2, b + 3));
    end
    reportTest("reset fill", errs);
  endtask

  // port 0 reads back the previous write, the others spread out
  task automatic randomWriteRead();
    int                  errs;
    int                  port;
    logic [ramIndex-1:0] lastAddr;
    logic [ramIndex-1:0] step;
    logic [numWrPorts-1:0] en;
    wrAddrs_t            wa;
    wrData_t             wd;
    errs     = errorCount;
    lastAddr = ramIndex'($urandom);
    for (int i = 0; i < numRandom; i++)
    begin
      port     = $urandom % numWrPorts;
      en       = '0;
      en[port] = 1'b1;
      wa[0]    = ramIndex'($urandom);
      wa[1]    = ramIndex'($urandom);
      wd[0]    = ramWidth'($urandom);
      wd[1]    = ramWidth'($urandom);
      // steps of 1..7 keep the four addresses apart
      step     = ramIndex'(1 + $urandom % 7);
      driveCycle(en, wa, wd, readAddrs(lastAddr, lastAddr + step, lastAddr + 2 * step,
                                       lastAddr + 3 * step));
      lastAddr = wa[port];
    end
    driveCycle('0, '0, '0, readAddrs(lastAddr, lastAddr, lastAddr, lastAddr));
    reportTest("write and read", errs);
  endtask

  // both ports on one word, one address per partition
  task automatic writeConflict();
    int                  errs;
    logic [ramIndex-1:0] a;
    logic [ramWidth-1:0] oldVal;
    wrData_t             wd;
    errs = errorCount;
    for (int p = 0; p < numParts; p++)
    begin
      a      = ramIndex'(p * partDepth + 3 + p);
      oldVal = model[a];
      wd[0]  = ramWidth'($urandom);
      wd[1]  = ~wd[0];
      driveCycle(2'b11, {a, a}, wd, readAddrs(a, a + 1, a - 1, a));
      checkWord("data_o[0] during write", dataRd[0], oldVal);
      driveCycle('0, '0, '0, readAddrs(a, a, a, a));
      checkWord("data_o[0] after conflict", dataRd[0], wd[1]);
    end
    reportTest("write conflict", errs);
  endtask

  // partition 2 hidden and frozen while the rest keeps working
  task automatic partitionGating();
    int errs;
    errs = errorCount;
    driveCycle(2'b11, {5'd5, 5'd17}, {16'h0505, 16'h1717}, readAddrs(0, 1, 2, 3));
    setGate(2, 1'b1);
    driveCycle('0, '0, '0, readAddrs(16, 17, 20, 5));
    checkWord("data_o[1] gated", dataRd[1], '0);
    driveCycle(2'b11, {5'd6, 5'd17}, {16'h0606, 16'hdead}, readAddrs(17, 6, 23, 8));
    driveCycle('0, '0, '0, readAddrs(17, 6, 22, 9));
    checkWord("data_o[1] beside gated", dataRd[1], 16'h0606);
    setGate(2, 1'b0);
    driveCycle('0, '0, '0, readAddrs(17, 16, 6, 5));
    checkWord("data_o[0] after ungate", dataRd[0], 16'h1717);
    reportTest("partition gating", errs);
  endtask

  // a write during the fill must not survive it
  task automatic writeDuringFill();
    int errs;
    errs = errorCount;
    applyReset();
    driveCycle(2'b11, {5'd31, 5'd8}, {16'hbeef, 16'hcafe}, readAddrs(8, 31, 0, 1));
    waitReady();
    driveCycle('0, '0, '0, readAddrs(8, 31, 0, 1));
    checkWord("data_o[0] after fill", dataRd[0], ramWidth'(seqStart + 8));
    reportTest("write before ready", errs);
  endtask

  initial
  begin
    void'($urandom(83));
    rst    = 1'b1;
    gated  = '0;
    addr   = '0;
    addrWr = '0;
    dataWr = '0;
    wrEn   = '0;
    for (int p = 0; p < numParts; p++)
    begin
      gateModel[p] = 1'b0;
    end
    resetModel();
    fillAfterReset();
    randomWriteRead();
    writeConflict();
    partitionGating();
    writeDuringFill();
    $display("checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0)
    begin
      $display("Simulation PASSED");
    end
    else
    begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/partitionedRam.sv ====
`timescale 1ns/1ps
`default_nettype none

module partitionedRam
(
  input  wire logic                                                  clk,
  input  wire logic                                                  rst_i,
  input  wire logic [ramPkg::numParts-1:0]                           partitionGated_i,
  input  wire logic [ramPkg::numRdPorts-1:0][ramPkg::ramIndex-1:0]   addr_i,
  input  wire logic [ramPkg::numWrPorts-1:0][ramPkg::ramIndex-1:0]   addrWr_i,
  input  wire logic [ramPkg::numWrPorts-1:0][ramPkg::ramWidth-1:0]   dataWr_i,
  input  wire logic [ramPkg::numWrPorts-1:0]                         wrEn_i,
  output logic [ramPkg::numRdPorts-1:0][ramPkg::ramWidth-1:0]        data_o,
  output logic                                                       ramReady_o
);

  import ramPkg::*;

  // word lines already cut per partition
  logic [numParts-1:0][numRdPorts-1:0][partDepth-1:0] rdWordLine;
  logic [numParts-1:0][numWrPorts-1:0][partDepth-1:0] wrWordLine;

  // partition picked by each read port
  logic [numRdPorts-1:0][numPartsLog-1:0] partSel;

  // every partition's candidate read data
  logic [numParts-1:0][numRdPorts-1:0][ramWidth-1:0] partData;

  logic [numParts-1:0] partReady;

  // shared decode, no partition has its own
  wordLineDecode decode_i
  (
    .addr_i       (addr_i),
    .addrWr_i     (addrWr_i),
    .rdWordLine_o (rdWordLine),
    .wrWordLine_o (wrWordLine),
    .partSel_o    (partSel)
  );

  // storage slices
  for (genvar p = 0; p < numParts; p++)
  begin : gPart
    // fill base so word i of the whole RAM becomes seqStart + i
    localparam logic [ramWidth-1:0] partBase = ramWidth'(seqStart + p * partDepth);

    // write data and enables are shared, only word lines differ
    ramPartition part_i
    (
      .clk          (clk),
      .rst_i        (rst_i),
      .gated_i      (partitionGated_i[p]),
      .seqBase_i    (partBase),
      .rdWordLine_i (rdWordLine[p]),
      .wrWordLine_i (wrWordLine[p]),
      .wrEn_i       (wrEn_i),
      .dataWr_i     (dataWr_i),
      .data_o       (partData[p]),
      .ready_o      (partReady[p])
    );
  end

  // pick the addressed partition per read port
  readSelect select_i
  (
    .partData_i (partData),
    .partSel_i  (partSel),
    .data_o     (data_o)
  );

  // RAM usable only when every slice has finished its fill
  assign ramReady_o = &partReady;

endmodule

`default_nettype wire

// ==== hdl/readSelect.sv ====
`timescale 1ns/1ps
`default_nettype none

module readSelect
(
  input  wire logic [ramPkg::numParts-1:0][ramPkg::numRdPorts-1:0][ramPkg::ramWidth-1:0]
    partData_i,
  input  wire logic [ramPkg::numRdPorts-1:0][ramPkg::numPartsLog-1:0] partSel_i,
  output logic [ramPkg::numRdPorts-1:0][ramPkg::ramWidth-1:0]         data_o
);

  import ramPkg::*;

  // result stage
  // every partition presents a word per read port, the top address
  // bits of that port decide which one leaves the RAM
  always_comb
  begin
    for (int rp = 0; rp < numRdPorts; rp++)
    begin
      data_o[rp] = partData_i[partSel_i[rp]][rp];
    end
  end

  // an unknown select would hand back garbage on a live read port
  for (genvar rp = 0; rp < numRdPorts; rp++)
  begin : gSelChk
    selKnownChk : assert final (!$isunknown(partSel_i[rp]))
      else $error("read port %0d partition select unknown", rp);
  end

endmodule

`default_nettype wire

// ==== hdl/ramPartition.sv ====
`timescale 1ns/1ps
`default_nettype none

module ramPartition
(
  input  wire logic                                                   clk,
  input  wire logic                                                   rst_i,
  input  wire logic                                                   gated_i,
  input  wire logic [ramPkg::ramWidth-1:0]                            seqBase_i,
  input  wire logic [ramPkg::numRdPorts-1:0][ramPkg::partDepth-1:0]   rdWordLine_i,
  input  wire logic [ramPkg::numWrPorts-1:0][ramPkg::partDepth-1:0]   wrWordLine_i,
  input  wire logic [ramPkg::numWrPorts-1:0]                          wrEn_i,
  input  wire logic [ramPkg::numWrPorts-1:0][ramPkg::ramWidth-1:0]    dataWr_i,
  output logic [ramPkg::numRdPorts-1:0][ramPkg::ramWidth-1:0]         data_o,
  output logic                                                        ready_o
);

  import ramPkg::*;

  // last local index visited by the fill sequence
  localparam logic [partIndex-1:0] fillLast = partIndex'(partDepth - 1);

  // storage words, filled by the sequencer rather than by reset
  logic [ramWidth-1:0] mem [partDepth];

  partState_e          state;
  logic [partIndex-1:0] fillCnt;
  logic [ramWidth-1:0] fillData;
  logic                wrAllowed;

  // fill sequencer
  // one word per cycle after reset release, then ready
  always_ff @(posedge clk)
  begin
    if (rst_i)
    begin
      state   <= PART_INIT;
      fillCnt <= '0;
    end
    else if (state == PART_INIT)
    begin
      fillCnt <= fillCnt + 1'b1;
      if (fillCnt == fillLast)
      begin
        state <= PART_READY;
      end
    end
  end

  assign ready_o = (state == PART_READY);

  // value loaded into the word under the fill counter
  always_comb
  begin
    if (ramResetMode == RESET_SEQ)
    begin
      fillData = seqBase_i + ramWidth'(fillCnt);
    end
    else
    begin
      fillData = '0;
    end
  end

  // normal writes only once filled, and never into a gated slice
  assign wrAllowed = (state == PART_READY) && !gated_i;

  // storage update
  // later ports are visited last, so the higher index wins a conflict
  always_ff @(posedge clk)
  begin
    if (state == PART_INIT)
    begin
      mem[fillCnt] <= fillData;
    end
    else if (wrAllowed)
    begin
      for (int wp = 0; wp < numWrPorts; wp++)
      begin
        for (int wd = 0; wd < partDepth; wd++)
        begin
          if (wrEn_i[wp] && wrWordLine_i[wp][wd])
          begin
            mem[wd] <= dataWr_i[wp];
          end
        end
      end
    end
  end

  // read path, AND-OR over the word lines
  // a slice whose words are not addressed returns zero and the
  // result stage discards it anyway
  always_comb
  begin
    for (int rp = 0; rp < numRdPorts; rp++)
    begin
      data_o[rp] = '0;
      for (int wd = 0; wd < partDepth; wd++)
      begin
        data_o[rp] = data_o[rp] | ({ramWidth{rdWordLine_i[rp][wd]}} & mem[wd]);
      end
      // gating hides the contents but leaves them in place
      if (gated_i)
      begin
        data_o[rp] = '0;
      end
    end
  end

  // once ready the slice stays ready until reset is seen again
  readyStableChk : assert property (
    @(posedge clk) disable iff (rst_i)
    $fell(ready_o) |-> $past(rst_i)
  ) else $error("partition ready dropped without reset");

  // an enabled write hits at most one word here
  // zero lines means the address belongs to another partition
  for (genvar wp = 0; wp < numWrPorts; wp++)
  begin : gWrChk
    wrLineChk : assert property (
      @(posedge clk) disable iff (rst_i)
      wrEn_i[wp] |-> $onehot0(wrWordLine_i[wp])
    ) else $error("write port %0d word lines not one-hot (%h)", wp, wrWordLine_i[wp]);
  end

endmodule

`default_nettype wire

// ==== hdl/wordLineDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module wordLineDecode
(
  input  wire logic [ramPkg::numRdPorts-1:0][ramPkg::ramIndex-1:0] addr_i,
  input  wire logic [ramPkg::numWrPorts-1:0][ramPkg::ramIndex-1:0] addrWr_i,
  output logic [ramPkg::numParts-1:0][ramPkg::numRdPorts-1:0][ramPkg::partDepth-1:0]
    rdWordLine_o,
  output logic [ramPkg::numParts-1:0][ramPkg::numWrPorts-1:0][ramPkg::partDepth-1:0]
    wrWordLine_o,
  output logic [ramPkg::numRdPorts-1:0][ramPkg::numPartsLog-1:0] partSel_o
);

  import ramPkg::*;

  // one full-depth one-hot word-line vector per port
  logic [ramDepth-1:0] rdDecoded [numRdPorts];
  logic [ramDepth-1:0] wrDecoded [numWrPorts];

  // single shared decode point for every read port
  for (genvar r = 0; r < numRdPorts; r++)
  begin : gRdDec
    assign rdDecoded[r] = ramDepth'(1) << addr_i[r];

    // upper address bits pick the partition that drives this port
    assign partSel_o[r] = addr_i[r][ramIndex-1 -: numPartsLog];

    // the set word line has to sit in the slice that partSel_o names
    // or the result stage would pass on an empty partition
    rdOneHotChk : assert final ($onehot(rdWordLine_o[partSel_o[r]][r]))
      else $error("read port %0d word line outside partition %0d", r, partSel_o[r]);
  end

  // write ports decode the same way
  for (genvar w = 0; w < numWrPorts; w++)
  begin : gWrDec
    assign wrDecoded[w] = ramDepth'(1) << addrWr_i[w];
  end

  // slice each full vector into partDepth-wide pieces
  // partition p owns words p*partDepth up to (p+1)*partDepth-1
  for (genvar p = 0; p < numParts; p++)
  begin : gSlice
    for (genvar r = 0; r < numRdPorts; r++)
    begin : gRdSlice
      assign rdWordLine_o[p][r] = rdDecoded[r][p*partDepth +: partDepth];
    end

    for (genvar w = 0; w < numWrPorts; w++)
    begin : gWrSlice
      assign wrWordLine_o[p][w] = wrDecoded[w][p*partDepth +: partDepth];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/ramPkg.sv ====
`default_nettype none

package ramPkg;

  // total words held by the register file
  localparam int ramDepth = 32;

  // address width across the full depth
  localparam int ramIndex = 5;

  // one data word
  localparam int ramWidth = 16;

  // asynchronous read ports and synchronous write ports
  localparam int numRdPorts = 4;
  localparam int numWrPorts = 2;

  // storage is cut into equal slices
  localparam int numParts    = 4;
  localparam int numPartsLog = 2;

  // words per partition and the local index width inside one
  localparam int partDepth = ramDepth / numParts;
  localparam int partIndex = ramIndex - numPartsLog;

  // what each word holds once the fill sequence completes
  typedef enum logic
  {
    RESET_ZERO,
    RESET_SEQ
  } resetMode_e;

  localparam resetMode_e ramResetMode = RESET_SEQ;

  // word i fills with seqStart + i in sequential mode
  localparam int seqStart = 0;

  // per partition fill state
  typedef enum logic
  {
    PART_INIT,
    PART_READY
  } partState_e;

endpackage

`default_nettype wire
